// File: src.f
+incdir+.
isa_pkg.sv
core_pkg.sv
instr_decoder.sv
alu_stage.sv
reg_file_wb.sv
int_exec_core.sv
tb_int_exec_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module tb_int_exec_core -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_int_exec_core > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Test failed" "$log"; then
    echo "simulation FAILED"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation PASSED"
exit 0

// File: tb_int_exec_core.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module tb_int_exec_core;
    import isa_pkg::*;
    import core_pkg::*;

    typedef struct packed {
        logic               wb;
        logic [`REG_AW-1:0] wreg;
        logic [`XLEN-1:0]   data;
        logic               exc;
        logic               ri;
        logic               ov;
    } outcome_t;

    // reset, register load, immediate, r-type, overflow, reserved, r0 and drain cycles
    localparam int stim_cycles = 233;
    localparam int max_cycles = 2 * stim_cycles;

    localparam logic [5:0] r_functs [16] = '{
        6'h20, 6'h21, 6'h22, 6'h23, 6'h2a, 6'h2b, 6'h24, 6'h25,
        6'h26, 6'h27, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07
    };
    localparam logic [5:0] imm_ops [6] = '{6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0e, 6'h08};

    logic      clk = 1'b0;
    logic      rst_n;
    logic      instr_valid;
    instr_u    instr;
    logic      wb_valid;
    reg_addr_t wb_reg;
    word_t     wb_data;
    logic      exc_valid;
    exc_t      exc;

    logic [`XLEN-1:0] model_regs [`NREGS];
    outcome_t         exp_q [$];
    integer           seed = 32'hecd4c92b;
    int               cycles = 0;

    int_exec_core i_dut (
        .clk, .rst_n, .instr_valid, .instr,
        .wb_valid, .wb_reg, .wb_data, .exc_valid, .exc
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] rtype_word(input logic [5:0] fn, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [4:0] rd,
                                               input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'($unsigned($random(seed)) % 31 + 1);
    endfunction

    // one instruction against the register model
    function automatic outcome_t predict(input logic [31:0] w);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sh;
        logic [4:0]  dst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [31:0] r;
        logic [32:0] wide;
        logic        ri;
        outcome_t    o;
        op = w[31:26];
        fn = w[5:0];
        sh = w[10:6];
        a = model_regs[w[25:21]];
        b = model_regs[w[20:16]];
        simm = {{16{w[15]}}, w[15:0]};
        zimm = {16'h0000, w[15:0]};
        dst = (op == 6'h00) ? w[15:11] : w[20:16];
        r = '0;
        ri = 1'b0;
        // sign-extended 33-bit sum whose top two bits differ on overflow
        wide = {a[31], a} + {simm[31], simm};
        case (op)
            6'h00: begin
                wide = (fn == 6'h22) ? {a[31], a} - {b[31], b} : {a[31], a} + {b[31], b};
                case (fn)
                    6'h00: r = b << sh;
                    6'h02: r = b >> sh;
                    6'h03: r = $signed(b) >>> sh;
                    6'h04: r = b << a[4:0];
                    6'h06: r = b >> a[4:0];
                    6'h07: r = $signed(b) >>> a[4:0];
                    6'h20, 6'h22: r = wide[31:0];
                    6'h21: r = a + b;
                    6'h23: r = a - b;
                    6'h24: r = a & b;
                    6'h25: r = a | b;
                    6'h26: r = a ^ b;
                    6'h27: r = ~(a | b);
                    6'h2a: r = {31'b0, $signed(a) < $signed(b)};
                    6'h2b: r = {31'b0, a < b};
                    default: ri = 1'b1;
                endcase
            end
            6'h08: r = wide[31:0];
            6'h09: r = a + simm;
            6'h0a: r = {31'b0, $signed(a) < $signed(simm)};
            6'h0b: r = {31'b0, a < simm};
            6'h0c: r = a & zimm;
            6'h0d: r = a | zimm;
            6'h0e: r = a ^ zimm;
            6'h0f: r = {w[15:0], 16'h0000};
            default: ri = 1'b1;
        endcase
        o = '0;
        if (ri) begin
            o.exc = 1'b1;
            o.ri = 1'b1;
        end else if ((op == 6'h08 || (op == 6'h00 && (fn == 6'h20 || fn == 6'h22)))
                     && wide[32] != wide[31]) begin
            o.exc = 1'b1;
            o.ov = 1'b1;
        end else if (dst != 5'd0) begin
            o.wb = 1'b1;
            o.wreg = dst;
            o.data = r;
            model_regs[dst] = r;
        end
        return o;
    endfunction

    task automatic issue(input logic [31:0] w);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr <= w;
        exp_q.push_back(predict(w));
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
            instr <= '0;
            exp_q.push_back('0);
        end
    endtask

    // lui then ori into the same register
    task automatic set_reg(input logic [4:0] rd, input logic [31:0] v);
        issue(itype_word(6'h0f, 5'd0, rd, v[31:16]));
        issue(itype_word(6'h0d, rd, rd, v[15:0]));
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, want);
        $display("Test failed");
        $fatal(1, "output check stopped the run");
    endtask

    // outcome of an instruction pushed three edges earlier
    always @(negedge clk) begin : check_outputs
        outcome_t e;
        e = (exp_q.size() >= 4) ? exp_q.pop_front() : '0;
        assert (wb_valid == e.wb)
            else report_mismatch("wb_valid", {31'b0, wb_valid}, {31'b0, e.wb});
        assert (exc_valid == e.exc)
            else report_mismatch("exc_valid", {31'b0, exc_valid}, {31'b0, e.exc});
        if (e.wb) begin
            assert (wb_reg == e.wreg)
                else report_mismatch("wb_reg", {27'b0, wb_reg}, {27'b0, e.wreg});
            assert (wb_data == e.data) else report_mismatch("wb_data", wb_data, e.data);
        end
        if (e.exc) begin
            assert (exc.ri == e.ri && exc.ov == e.ov)
                else report_mismatch("exc", {30'b0, exc.ri, exc.ov}, {30'b0, e.ri, e.ov});
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("timeout: run still going after %0d cycles", max_cycles);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    initial begin : stimulus
        logic [4:0] rd;
        logic [4:0] prev1;
        logic [4:0] prev2;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        for (int n = 0; n < `NREGS; n++) begin
            model_regs[n] = '0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        idle(3);
        for (int n = 1; n < `NREGS; n++) begin
            set_reg(5'(n), $random(seed));
        end
        for (int n = 0; n < 24; n++) begin
            issue(itype_word(imm_ops[$unsigned($random(seed)) % 6], rand_reg(), rand_reg(),
                             16'($random(seed))));
        end
        // rs from the previous result, rt from the one before
        prev1 = rand_reg();
        prev2 = rand_reg();
        for (int n = 0; n < 96; n++) begin
            rd = rand_reg();
            issue(rtype_word(r_functs[n % 16], prev1, prev2, rd, 5'($random(seed))));
            prev2 = prev1;
            prev1 = rd;
        end
        set_reg(5'd1, 32'h7fff_ffff);
        set_reg(5'd2, 32'h0000_0001);
        set_reg(5'd3, 32'h8000_0000);
        issue(rtype_word(6'h20, 5'd1, 5'd2, 5'd4, 5'd0));
        issue(rtype_word(6'h25, 5'd4, 5'd0, 5'd7, 5'd0));
        issue(rtype_word(6'h21, 5'd1, 5'd2, 5'd4, 5'd0));
        issue(rtype_word(6'h22, 5'd3, 5'd2, 5'd5, 5'd0));
        issue(rtype_word(6'h25, 5'd5, 5'd0, 5'd7, 5'd0));
        issue(rtype_word(6'h23, 5'd3, 5'd2, 5'd5, 5'd0));
        issue(itype_word(6'h08, 5'd1, 5'd6, 16'h0001));
        issue(rtype_word(6'h25, 5'd6, 5'd0, 5'd7, 5'd0));
        issue(itype_word(6'h09, 5'd1, 5'd6, 16'h0001));
        // lw, j, sync, mult, undefined funct, then random words
        issue(itype_word(6'h23, 5'd1, 5'd9, 16'h0010));
        issue(itype_word(6'h02, 5'd0, 5'd0, 16'h0040));
        issue(rtype_word(6'h0f, 5'd0, 5'd0, 5'd0, 5'd0));
        issue(rtype_word(6'h18, 5'd1, 5'd2, 5'd0, 5'd0));
        issue(rtype_word(6'h01, 5'd1, 5'd2, 5'd9, 5'd0));
        for (int n = 0; n < 12; n++) begin
            issue($random(seed));
        end
        issue(itype_word(6'h09, 5'd5, 5'd0, 16'h007b));
        issue(itype_word(6'h0d, 5'd6, 5'd0, 16'hffff));
        issue(rtype_word(6'h21, 5'd1, 5'd2, 5'd0, 5'd0));
        issue(rtype_word(6'h25, 5'd0, 5'd0, 5'd7, 5'd0));
        issue(itype_word(6'h09, 5'd0, 5'd8, 16'h0005));
        idle(6);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: int_exec_core.sv
`timescale 1ns/1ps

module int_exec_core (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  isa_pkg::instr_u     instr,
    output logic                wb_valid,
    output core_pkg::reg_addr_t wb_reg,
    output core_pkg::word_t     wb_data,
    output logic                exc_valid,
    output core_pkg::exc_t      exc
);
    import core_pkg::*;

    ex_req_t   ex_req;
    wb_req_t   wb_req;
    bypass_t   ex_fwd;
    bypass_t   wb_fwd;
    reg_addr_t raddr_a;
    reg_addr_t raddr_b;
    word_t     rdata_a;
    word_t     rdata_b;

    instr_decoder i_dec (
        .clk, .rst_n, .instr_valid, .instr, .rdata_a, .rdata_b,
        .ex_fwd, .wb_fwd, .raddr_a, .raddr_b, .ex_req
    );

    alu_stage i_alu (
        .clk, .rst_n, .ex_req, .ex_fwd, .wb_req
    );

    reg_file_wb i_rf (
        .clk, .rst_n, .wb_req, .raddr_a, .raddr_b, .rdata_a, .rdata_b,
        .wb_fwd, .wb_valid, .wb_reg, .wb_data, .exc_valid, .exc
    );

endmodule

// File: reg_file_wb.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module reg_file_wb (
    input  logic                clk,
    input  logic                rst_n,
    input  core_pkg::wb_req_t   wb_req,
    input  core_pkg::reg_addr_t raddr_a,
    input  core_pkg::reg_addr_t raddr_b,
    output core_pkg::word_t     rdata_a,
    output core_pkg::word_t     rdata_b,
    output core_pkg::bypass_t   wb_fwd,
    output logic                wb_valid,
    output core_pkg::reg_addr_t wb_reg,
    output core_pkg::word_t     wb_data,
    output logic                exc_valid,
    output core_pkg::exc_t      exc
);
    import core_pkg::*;

    word_t regs [`NREGS];
    logic  do_write;

    assign do_write = wb_req.valid && wb_req.regwrite && wb_req.destreg != '0;

    // r0 reads as zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    assign wb_fwd = '{valid: do_write, destreg: wb_req.destreg, data: wb_req.data};

    // all registers start at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int n = 0; n < `NREGS; n++) begin
                regs[n] <= '0;
            end
        end else if (do_write) begin
            regs[wb_req.destreg] <= wb_req.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            exc_valid <= 1'b0;
            exc <= '0;
        end else begin
            wb_valid <= do_write;
            exc_valid <= wb_req.valid && (wb_req.exc.ri || wb_req.exc.ov);
            exc <= wb_req.exc;
        end
    end

    always_ff @(posedge clk) begin
        wb_reg <= wb_req.destreg;
        wb_data <= wb_req.data;
    end

endmodule

// File: alu_stage.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module alu_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  core_pkg::ex_req_t ex_req,
    output core_pkg::bypass_t ex_fwd,
    output core_pkg::wb_req_t wb_req
);
    import core_pkg::*;

    dec_ctl_t            ctl;
    word_t               a;
    word_t               b;
    word_t               sum;
    word_t               diff;
    word_t               result;
    logic [`SHAMT_W-1:0] sa;
    logic                ovf;
    logic                ov;
    logic                wr;
    logic                valid_q;
    logic                regwrite_q;
    reg_addr_t           destreg_q;
    word_t               data_q;
    exc_t                exc_q;

    assign ctl = ex_req.ctl;
    assign a   = ex_req.srca;

    always_comb begin
        if (!ctl.use_imm) begin
            b = ex_req.srcb;
        end else if (ctl.zeroext) begin
            b = {{(`XLEN-16){1'b0}}, ctl.imm16};
        end else begin
            b = {{(`XLEN-16){ctl.imm16[15]}}, ctl.imm16};
        end
    end

    assign sum  = a + b;
    assign diff = a - b;
    // variable shifts take rs[4:0]
    assign sa   = ctl.shamt_valid ? ctl.shamt : a[`SHAMT_W-1:0];

    always_comb begin
        case (ctl.alufunc)
            ALU_ADD, ALU_ADDU: result = sum;
            ALU_SUB, ALU_SUBU: result = diff;
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, a < b};
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLL:  result = b << sa;
            ALU_SRL:  result = b >> sa;
            ALU_SRA:  result = $signed(b) >>> sa;
            ALU_LUI:  result = {ctl.imm16, {(`XLEN-16){1'b0}}};
            default:  result = '0;
        endcase
    end

    // signed overflow: operand signs vs result sign
    assign ovf = (ctl.alufunc == ALU_SUB) ?
                 (a[`XLEN-1] != b[`XLEN-1]) && (diff[`XLEN-1] != a[`XLEN-1]) :
                 (a[`XLEN-1] == b[`XLEN-1]) && (sum[`XLEN-1] != a[`XLEN-1]);
    assign ov  = ex_req.valid && ctl.trap_ov && ovf;
    assign wr  = ex_req.valid && ctl.regwrite && !ov;

    assign ex_fwd = '{valid: wr, destreg: ctl.destreg, data: result};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            regwrite_q <= 1'b0;
            destreg_q <= '0;
            exc_q <= '0;
        end else begin
            valid_q <= ex_req.valid;
            regwrite_q <= wr;
            destreg_q <= ctl.destreg;
            exc_q <= '{ri: ex_req.valid && ctl.ri, ov: ov};
        end
    end

    always_ff @(posedge clk) begin
        data_q <= result;
    end

    assign wb_req = '{valid: valid_q, regwrite: regwrite_q, destreg: destreg_q,
                      data: data_q, exc: exc_q};

endmodule

// File: instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  isa_pkg::instr_u     instr,
    input  core_pkg::word_t     rdata_a,
    input  core_pkg::word_t     rdata_b,
    input  core_pkg::bypass_t   ex_fwd,
    input  core_pkg::bypass_t   wb_fwd,
    output core_pkg::reg_addr_t raddr_a,
    output core_pkg::reg_addr_t raddr_b,
    output core_pkg::ex_req_t   ex_req
);
    import isa_pkg::*;
    import core_pkg::*;

    dec_ctl_t  ctl;
    reg_addr_t src_a;
    reg_addr_t src_b;
    logic      valid_q;
    dec_ctl_t  ctl_q;
    word_t     srca_q;
    word_t     srcb_q;

    // youngest producer wins, r0 never forwarded
    function automatic word_t resolve(input reg_addr_t addr, input word_t rdata,
                                      input bypass_t ex_f, input bypass_t wb_f);
        if (addr == '0) return '0;
        if (ex_f.valid && ex_f.destreg == addr) return ex_f.data;
        if (wb_f.valid && wb_f.destreg == addr) return wb_f.data;
        return rdata;
    endfunction

    always_comb begin
        ctl = '0;
        src_a = '0;
        src_b = '0;
        ctl.shamt = instr.r.shamt;
        ctl.imm16 = instr.i.imm16;
        if (instr_valid) begin
            ctl.regwrite = 1'b1;
            if (instr.i.opcode == OP_SPECIAL) begin
                src_a = instr.r.rs;
                src_b = instr.r.rt;
                ctl.destreg = instr.r.rd;
            end else begin
                src_a = instr.i.rs;
                ctl.destreg = instr.i.rt;
                ctl.use_imm = 1'b1;
            end
            case (instr.i.opcode)
                OP_SPECIAL: begin
                    case (instr.r.funct)
                        F_ADD: begin
                            ctl.alufunc = ALU_ADD;
                            ctl.trap_ov = 1'b1;
                        end
                        F_ADDU: ctl.alufunc = ALU_ADDU;
                        F_SUB: begin
                            ctl.alufunc = ALU_SUB;
                            ctl.trap_ov = 1'b1;
                        end
                        F_SUBU: ctl.alufunc = ALU_SUBU;
                        F_SLT:  ctl.alufunc = ALU_SLT;
                        F_SLTU: ctl.alufunc = ALU_SLTU;
                        F_AND:  ctl.alufunc = ALU_AND;
                        F_OR:   ctl.alufunc = ALU_OR;
                        F_XOR:  ctl.alufunc = ALU_XOR;
                        F_NOR:  ctl.alufunc = ALU_NOR;
                        F_SLLV: ctl.alufunc = ALU_SLL;
                        F_SRLV: ctl.alufunc = ALU_SRL;
                        F_SRAV: ctl.alufunc = ALU_SRA;
                        F_SLL, F_SRL, F_SRA: begin
                            // shift by the shamt field, rs unused
                            ctl.alufunc = (instr.r.funct == F_SLL) ? ALU_SLL :
                                          (instr.r.funct == F_SRL) ? ALU_SRL : ALU_SRA;
                            ctl.shamt_valid = 1'b1;
                            src_a = '0;
                        end
                        default: ctl.ri = 1'b1;
                    endcase
                end
                OP_ADDI: begin
                    ctl.alufunc = ALU_ADD;
                    ctl.trap_ov = 1'b1;
                end
                OP_ADDIU: ctl.alufunc = ALU_ADDU;
                OP_SLTI:  ctl.alufunc = ALU_SLT;
                OP_SLTIU: ctl.alufunc = ALU_SLTU;
                OP_ANDI, OP_ORI, OP_XORI: begin
                    ctl.alufunc = (instr.i.opcode == OP_ANDI) ? ALU_AND :
                                  (instr.i.opcode == OP_ORI)  ? ALU_OR : ALU_XOR;
                    ctl.zeroext = 1'b1;
                end
                OP_LUI: begin
                    ctl.alufunc = ALU_LUI;
                    src_a = '0;
                end
                default: ctl.ri = 1'b1;
            endcase
            // reserved: no sources, no destination
            if (ctl.ri) begin
                ctl.regwrite = 1'b0;
                ctl.destreg = '0;
                src_a = '0;
                src_b = '0;
            end
            if (ctl.regwrite && ctl.destreg == '0) begin
                ctl.regwrite = 1'b0;
            end
        end
    end

    assign raddr_a = src_a;
    assign raddr_b = src_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            ctl_q <= '0;
        end else begin
            valid_q <= instr_valid;
            ctl_q <= ctl;
        end
    end

    always_ff @(posedge clk) begin
        srca_q <= resolve(src_a, rdata_a, ex_fwd, wb_fwd);
        srcb_q <= resolve(src_b, rdata_b, ex_fwd, wb_fwd);
    end

    assign ex_req = '{valid: valid_q, ctl: ctl_q, srca: srca_q, srcb: srcb_q};

endmodule

// File: core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

    typedef logic [`XLEN-1:0]   word_t;
    typedef logic [`REG_AW-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL,
        ALU_SRA, ALU_LUI
    } alu_func_e;

    typedef struct packed {
        logic ri;
        logic ov;
    } exc_t;

    typedef struct packed {
        alu_func_e              alufunc;
        logic                   regwrite;
        logic                   trap_ov;
        logic                   use_imm;
        logic                   zeroext;
        logic                   shamt_valid;
        logic                   ri;
        reg_addr_t              destreg;
        logic [`SHAMT_W-1:0]    shamt;
        logic [15:0]            imm16;
    } dec_ctl_t;

    // decode to execute
    typedef struct packed {
        logic       valid;
        dec_ctl_t   ctl;
        word_t      srca;
        word_t      srcb;
    } ex_req_t;

    // execute to result, regwrite already dropped on overflow
    typedef struct packed {
        logic       valid;
        logic       regwrite;
        reg_addr_t  destreg;
        word_t      data;
        exc_t       exc;
    } wb_req_t;

    typedef struct packed {
        logic       valid;
        reg_addr_t  destreg;
        word_t      data;
    } bypass_t;

endpackage

// File: isa_pkg.sv
`include "core_cfg.svh"

package isa_pkg;

    // major opcodes kept by the core
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111
    } opcode_e;

    // funct codes under SPECIAL
    typedef enum logic [5:0] {
        F_SLL  = 6'b000000,
        F_SRL  = 6'b000010,
        F_SRA  = 6'b000011,
        F_SLLV = 6'b000100,
        F_SRLV = 6'b000110,
        F_SRAV = 6'b000111,
        F_ADD  = 6'b100000,
        F_ADDU = 6'b100001,
        F_SUB  = 6'b100010,
        F_SUBU = 6'b100011,
        F_AND  = 6'b100100,
        F_OR   = 6'b100101,
        F_XOR  = 6'b100110,
        F_NOR  = 6'b100111,
        F_SLT  = 6'b101010,
        F_SLTU = 6'b101011
    } funct_e;

    typedef struct packed {
        opcode_e                opcode;
        logic [`REG_AW-1:0]     rs;
        logic [`REG_AW-1:0]     rt;
        logic [`REG_AW-1:0]     rd;
        logic [`SHAMT_W-1:0]    shamt;
        funct_e                 funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e                opcode;
        logic [`REG_AW-1:0]     rs;
        logic [`REG_AW-1:0]     rt;
        logic [15:0]            imm16;
    } i_fmt_t;

    // same word, two field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

// File: core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// datapath width
`define XLEN 32

// general purpose registers
`define NREGS 32

// register index width
`define REG_AW 5

// shift amount field width
`define SHAMT_W 5

`endif
